// File: hdl/net_pkg.sv
// shared types and protocol constants for the ethernet frame transmitter
`default_nettype none

package net_pkg;

  // --------------------------------------------------------------------------
  // addresses
  // --------------------------------------------------------------------------
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;

  // own station identity
  typedef struct packed {
    mac_addr_t mac;
    ip_addr_t  ip;
  } local_cfg_t;

  // who asked for our mac
  typedef struct packed {
    mac_addr_t mac;
    ip_addr_t  ip;
  } arp_target_t;

  // udp destination, frozen while run is high
  typedef struct packed {
    mac_addr_t   mac;
    ip_addr_t    ip;
    logic [15:0] port;
  } udp_dest_t;

  // --------------------------------------------------------------------------
  // generator to transmitter, transmitter to phy side
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [7:0] data;     // byte at the generator's counter
    logic       last;     // final body byte
    mac_addr_t  dest_mac; // goes into the mac header
  } body_t;

  typedef struct packed {
    logic       en;
    logic [7:0] data;
  } tx_byte_t;

  typedef enum logic {
    PROTO_ARP,
    PROTO_UDP
  } proto_e;

  typedef enum logic [1:0] {
    FS_IDLE,
    FS_MAC_HDR,
    FS_BODY,
    FS_GAP
  } frame_state_e;

  // --------------------------------------------------------------------------
  // protocol constants
  // --------------------------------------------------------------------------
  localparam logic [15:0] ETHERTYPE_IP  = 16'h0800;
  localparam logic [15:0] ETHERTYPE_ARP = 16'h0806;

  localparam int MAC_HDR_LEN  = 14;
  localparam int ARP_BODY_LEN = 28;
  localparam int IP_HDR_LEN   = 20;
  localparam int UDP_HDR_LEN  = 8;

  localparam logic [7:0]  IP_PROTO_UDP = 8'd17;
  localparam logic [15:0] IP_FLAGS_DF  = 16'h4000; // don't fragment, offset 0

  localparam logic [15:0] ARP_HTYPE_ETH = 16'h0001;
  localparam logic [15:0] ARP_OP_REPLY  = 16'h0002;

endpackage

`default_nettype wire

// File: hdl/arp_reply_gen.sv
// arp reply generator: holds the latest request and serves the 28-byte reply body
`default_nettype none

module arp_reply_gen import net_pkg::*; (
  input  wire logic        tx_clock,
  input  wire logic        rst_n,
  input  wire local_cfg_t  cfg,
  input  wire logic        arp_request,  // one-cycle capture strobe
  input  wire arp_target_t arp_target,
  input  wire logic        start,        // frame granted to us
  input  wire logic        advance,      // step to next body byte
  output logic             pending,
  output body_t            body
);

  arp_target_t     tgt_q;      // waiting request, newest wins
  arp_target_t     cur_q;      // copy used by the frame on the wire
  logic            pending_q;
  logic [4:0]      cnt_q;      // body byte index
  logic [0:31][7:0] bytes;     // body image padded to 32 bytes

  // --------------------------------------------------------------------------
  // control
  // --------------------------------------------------------------------------
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      pending_q <= 1'b0;
      cnt_q     <= '0;
    end else begin
      if (arp_request)
        pending_q <= 1'b1;          // a fresh request outranks the clear
      else if (start)
        pending_q <= 1'b0;

      if (start)
        cnt_q <= '0;
      else if (advance)
        cnt_q <= cnt_q + 5'd1;
    end
  end

  // target storage
  always_ff @(posedge tx_clock) begin
    if (arp_request)
      tgt_q <= arp_target;
    if (start)
      cur_q <= tgt_q;               // freeze for the frame in flight
  end

  // --------------------------------------------------------------------------
  // reply body
  // --------------------------------------------------------------------------
  assign bytes = {
    ARP_HTYPE_ETH,                  // hardware type
    ETHERTYPE_IP,                   // protocol type
    8'd6, 8'd4,                     // hlen, plen
    ARP_OP_REPLY,
    cfg.mac, cfg.ip,                // sender
    cur_q.mac, cur_q.ip,            // target
    32'h0                           // pad, never sent
  };

  assign pending       = pending_q;
  assign body.data     = bytes[cnt_q];
  assign body.last     = (cnt_q == 5'(ARP_BODY_LEN - 1));
  assign body.dest_mac = tgt_q.mac;  // sampled by the transmitter at grant

endmodule

`default_nettype wire

// File: hdl/udp_ip_gen.sv
// udp/ipv4 body generator with destination latch and ipv4 header checksum
`default_nettype none

module udp_ip_gen import net_pkg::*; #(
  parameter logic [15:0] UDP_SRC_PORT = 16'd1024,
  parameter logic [7:0]  IP_TTL       = 8'd128
) (
  input  wire logic        tx_clock,
  input  wire logic        rst_n,
  input  wire local_cfg_t  cfg,
  input  wire logic        udp_tx_request,
  input  wire logic [15:0] udp_tx_length,  // payload bytes, stable while requesting
  input  wire logic [7:0]  udp_tx_data,
  input  wire udp_dest_t   udp_dest,
  input  wire logic        run,
  input  wire logic        start,
  input  wire logic        advance,
  output logic             pending,
  output logic             udp_read,       // payload byte taken this cycle
  output body_t            body
);

  udp_dest_t        dest_q;
  logic [15:0]      tot_len_q;   // ip total length, 28 + payload
  logic [15:0]      cks_q;
  logic [15:0]      cnt_q;       // body byte index
  logic [15:0]      tot_len_in;
  logic [15:0]      udp_len;
  logic             in_payload;
  logic [0:31][7:0] hdr_bytes;   // ip + udp header, padded to 32 bytes

  // ones-complement sum of the ip header, checksum word taken as zero
  function automatic logic [15:0] ip_checksum(
    input logic [15:0] tot_len,
    input ip_addr_t    src,
    input ip_addr_t    dst
  );
    logic [19:0] sum;
    sum = 20'h04500 + tot_len + IP_FLAGS_DF + {IP_TTL, IP_PROTO_UDP}
        + src[31:16] + src[15:0] + dst[31:16] + dst[15:0];
    sum = sum[15:0] + sum[19:16];   // fold carries
    sum = sum[15:0] + sum[19:16];   // second fold catches the last carry
    return ~sum[15:0];
  endfunction

  // --------------------------------------------------------------------------
  // destination latch, transparent while run is low
  // --------------------------------------------------------------------------
  always_ff @(posedge tx_clock) begin
    if (!run)
      dest_q <= udp_dest;
  end

  // --------------------------------------------------------------------------
  // per-frame capture and byte counter
  // --------------------------------------------------------------------------
  assign tot_len_in = udp_tx_length + 16'(IP_HDR_LEN + UDP_HDR_LEN);

  always_ff @(posedge tx_clock) begin
    if (start) begin
      tot_len_q <= tot_len_in;
      cks_q     <= ip_checksum(tot_len_in, cfg.ip, dest_q.ip); // ready long before byte 10
    end
  end

  always_ff @(posedge tx_clock) begin
    if (!rst_n)
      cnt_q <= '0;
    else if (start)
      cnt_q <= '0;
    else if (advance)
      cnt_q <= cnt_q + 16'd1;
  end

  // --------------------------------------------------------------------------
  // body bytes
  // --------------------------------------------------------------------------
  assign udp_len    = tot_len_q - 16'(IP_HDR_LEN);
  assign in_payload = (cnt_q >= 16'(IP_HDR_LEN + UDP_HDR_LEN));

  assign hdr_bytes = {
    8'h45, 8'h00,                   // version/ihl, tos
    tot_len_q,
    16'h0000,                       // identification
    IP_FLAGS_DF,
    IP_TTL, IP_PROTO_UDP,
    cks_q,
    cfg.ip, dest_q.ip,
    UDP_SRC_PORT, dest_q.port,      // udp header from here
    udp_len,
    16'h0000,                       // udp checksum unused
    32'h0                           // pad
  };

  assign pending  = udp_tx_request;
  assign udp_read = advance && in_payload;

  // payload bytes pass straight through from the requester
  assign body.data     = in_payload ? udp_tx_data : hdr_bytes[cnt_q[4:0]];
  assign body.last     = (cnt_q == tot_len_q - 16'd1);
  assign body.dest_mac = dest_q.mac;

endmodule

`default_nettype wire

// File: hdl/eth_frame_tx.sv
// frame transmitter with arp-first arbitration, mac header and byte serialization
`default_nettype none

module eth_frame_tx import net_pkg::*; (
  input  wire logic       tx_clock,
  input  wire logic       rst_n,
  input  wire local_cfg_t cfg,
  input  wire logic       arp_pending,
  input  wire body_t      arp_body,
  input  wire logic       udp_pending,
  input  wire body_t      udp_body,
  output logic            arp_start,
  output logic            udp_start,
  output logic            arp_advance,
  output logic            udp_advance,
  output logic            udp_tx_enable,  // grant seen by the udp requester
  output tx_byte_t        frame_out,
  output logic            tx_active
);

  frame_state_e     state_q;
  proto_e           proto_q;      // protocol of the frame in flight
  proto_e           pick;         // winner if we start now
  mac_addr_t        dest_q;
  mac_addr_t        pick_dest;
  logic [3:0]       hdr_cnt_q;    // next mac header byte
  logic             en_q;
  logic [7:0]       data_q;
  logic             arp_start_q;
  logic             udp_start_q;
  body_t            cur_body;
  logic [0:15][7:0] hdr_bytes;    // 14-byte mac header plus pad
  logic [7:0]       next_byte;

  // --------------------------------------------------------------------------
  // selection
  // --------------------------------------------------------------------------
  assign pick      = arp_pending ? PROTO_ARP : PROTO_UDP;   // arp always first
  assign pick_dest = arp_pending ? arp_body.dest_mac : udp_body.dest_mac;
  assign cur_body  = (proto_q == PROTO_ARP) ? arp_body : udp_body;

  assign hdr_bytes = {
    dest_q,
    cfg.mac,
    (proto_q == PROTO_ARP) ? ETHERTYPE_ARP : ETHERTYPE_IP,
    16'h0000                      // pad
  };

  always_comb begin
    case (state_q)
      FS_IDLE:    next_byte = pick_dest[47:40];   // first dest byte goes out at grant
      FS_MAC_HDR: next_byte = hdr_bytes[hdr_cnt_q];
      FS_BODY:    next_byte = cur_body.data;
      default:    next_byte = 8'h00;
    endcase
  end

  // --------------------------------------------------------------------------
  // frame FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      state_q     <= FS_IDLE;
      hdr_cnt_q   <= '0;
      en_q        <= 1'b0;
      arp_start_q <= 1'b0;
      udp_start_q <= 1'b0;
    end else begin
      arp_start_q <= 1'b0;        // starts are single cycle
      udp_start_q <= 1'b0;
      case (state_q)
        FS_IDLE: begin
          hdr_cnt_q <= 4'd1;
          if (arp_pending || udp_pending) begin
            state_q     <= FS_MAC_HDR;
            en_q        <= 1'b1;
            arp_start_q <= arp_pending;
            udp_start_q <= !arp_pending;
          end
        end
        FS_MAC_HDR: begin
          hdr_cnt_q <= hdr_cnt_q + 4'd1;
          if (hdr_cnt_q == 4'(MAC_HDR_LEN - 1))
            state_q <= FS_BODY;
        end
        FS_BODY:
          if (cur_body.last)
            state_q <= FS_GAP;    // last byte loads on this edge
        FS_GAP: begin
          en_q    <= 1'b0;        // one dead cycle between frames
          state_q <= FS_IDLE;
        end
        default: state_q <= FS_IDLE;
      endcase
    end
  end

  // output byte and per-frame choices
  always_ff @(posedge tx_clock) begin
    data_q <= next_byte;
    if (state_q == FS_IDLE) begin
      proto_q <= pick;
      dest_q  <= pick_dest;
    end
  end

  // --------------------------------------------------------------------------
  // outputs
  // --------------------------------------------------------------------------
  assign arp_start     = arp_start_q;
  assign udp_start     = udp_start_q;
  assign udp_tx_enable = udp_start_q;
  assign arp_advance   = (state_q == FS_BODY) && (proto_q == PROTO_ARP);
  assign udp_advance   = (state_q == FS_BODY) && (proto_q == PROTO_UDP);
  assign frame_out     = '{en: en_q, data: data_q};
  assign tx_active     = (state_q != FS_IDLE);  // busy from grant through the gap cycle

endmodule

`default_nettype wire

// File: hdl/net_tx_top.sv
// network transmit top: arp and udp/ip generators feeding the frame transmitter
`default_nettype none

module net_tx_top import net_pkg::*; #(
  parameter logic [15:0] UDP_SRC_PORT = 16'd1024,
  parameter logic [7:0]  IP_TTL       = 8'd128
) (
  input  wire logic        tx_clock,
  input  wire logic        rst_n,
  input  wire local_cfg_t  cfg,
  input  wire logic        arp_request,
  input  wire arp_target_t arp_target,
  input  wire logic        udp_tx_request,
  input  wire logic [15:0] udp_tx_length,
  input  wire logic [7:0]  udp_tx_data,
  input  wire udp_dest_t   udp_dest,
  input  wire logic        run,
  output logic             udp_tx_enable,
  output logic             udp_read,
  output tx_byte_t         frame_out,
  output logic             tx_active
);

  logic  arp_pending, udp_pending;
  logic  arp_start, udp_start;
  logic  arp_advance, udp_advance;
  body_t arp_body, udp_body;

  // --------------------------------------------------------------------------
  // generators
  // --------------------------------------------------------------------------
  arp_reply_gen u_arp (
    .tx_clock, .rst_n, .cfg, .arp_request, .arp_target,
    .start   (arp_start),
    .advance (arp_advance),
    .pending (arp_pending),
    .body    (arp_body)
  );

  udp_ip_gen #(
    .UDP_SRC_PORT (UDP_SRC_PORT),
    .IP_TTL       (IP_TTL)
  ) u_udp (
    .tx_clock, .rst_n, .cfg, .udp_tx_request, .udp_tx_length, .udp_tx_data,
    .udp_dest, .run, .udp_read,
    .start   (udp_start),
    .advance (udp_advance),
    .pending (udp_pending),
    .body    (udp_body)
  );

  // arbitration and serializer
  eth_frame_tx u_tx (
    .tx_clock, .rst_n, .cfg, .arp_pending, .arp_body, .udp_pending, .udp_body,
    .arp_start, .udp_start, .arp_advance, .udp_advance,
    .udp_tx_enable, .frame_out, .tx_active
  );

endmodule

`default_nettype wire

// File: tests/net_tx_assert.sv
// frame transmitter checker: start exclusivity, enable alignment and inter-frame gap
`default_nettype none

module net_tx_assert import net_pkg::*; (
  input wire logic     tx_clock,
  input wire logic     rst_n,
  input wire logic     arp_start,
  input wire logic     udp_start,
  input wire tx_byte_t frame_out,
  input wire logic     tx_active
);

  timeunit 1ns;
  timeprecision 100ps;

  // ---------------------------------------------------------------------------
  // protocol properties
  // ---------------------------------------------------------------------------
  one_start_at_a_time: assert property (
    @(posedge tx_clock) disable iff (!rst_n) !(arp_start && udp_start)
  ) else $error("arp and udp start pulses high together");

  en_follows_active: assert property (
    @(posedge tx_clock) disable iff (!rst_n) frame_out.en == tx_active
  ) else $error("frame_out.en differs from tx_active");

  // a start cycle is the first frame byte, so the cycle before must be idle
  gap_before_frame: assert property (
    @(posedge tx_clock) disable iff (!rst_n) (arp_start || udp_start) |-> !$past(tx_active)
  ) else $error("frame started with no idle gap cycle");

endmodule

bind eth_frame_tx net_tx_assert i_assert (
  .tx_clock  (tx_clock),
  .rst_n     (rst_n),
  .arp_start (arp_start),
  .udp_start (udp_start),
  .frame_out (frame_out),
  .tx_active (tx_active)
);

`default_nettype wire

// File: tests/net_tx_tb.sv
// testbench for the network transmit top with a table of arp and udp frames checked against a model
`default_nettype none

module net_tx_tb import net_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [1:0]  kind;      // 0 arp, 1 udp, 2 arp and udp together
    mac_addr_t   mac;
    ip_addr_t    ip;
    logic [15:0] port;
    logic [15:0] len;
    logic [1:0]  run_mode;  // 0 run low, 1 run high (frozen), 2 run toggles
  } entry_t;

  localparam int N_ENTRIES = 8;

  logic tx_clock, rst_n, arp_request, udp_tx_request, run;
  logic udp_tx_enable, udp_read, tx_active;
  local_cfg_t  cfg;
  arp_target_t arp_target;
  udp_dest_t   udp_dest, exp_dest;
  logic [15:0] udp_tx_length;
  logic [7:0]  udp_tx_data;
  tx_byte_t    frame_out;

  entry_t      table_e [N_ENTRIES];
  logic [7:0]  pay [64];
  logic [7:0]  exp_q [$];
  logic [7:0]  cap_q [$];
  logic [15:0] lfsr;
  int          pay_idx, frames_done, errors, timeouts;
  logic        read_seen, enable_seen, en_prev;

  net_tx_top i_dut (.*);

  initial begin
    tx_clock = 1'b0;
    forever #50 tx_clock = ~tx_clock;
  end

  // --------------------------------------------------------------------------
  // monitors and payload source
  // --------------------------------------------------------------------------
  always @(negedge tx_clock) begin
    read_seen   = udp_read;
    enable_seen = udp_tx_enable;
    if (frame_out.en)
      cap_q.push_back(frame_out.data);
    if (en_prev && !frame_out.en)
      frames_done++;            // end of a frame
    en_prev = frame_out.en;
  end

  always @(posedge tx_clock) begin
    if (read_seen) begin
      pay_idx = pay_idx + 1;    // requester moves on after each read
      udp_tx_data <= pay[pay_idx];
    end
  end

  // fibonacci lfsr with taps 16 14 13 11
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  task automatic push_bytes(input logic [47:0] v, input int n);
    for (int i = n - 1; i >= 0; i--)
      exp_q.push_back(v[i*8 +: 8]);
  endtask

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------
  task automatic model_arp(input mac_addr_t mac, input ip_addr_t ip);
    push_bytes(mac, 6);
    push_bytes(cfg.mac, 6);
    push_bytes(48'h0806, 2);
    push_bytes(48'h0001_0800_0604, 6);  // htype, ptype, hlen, plen
    push_bytes(48'h0002, 2);            // reply
    push_bytes(cfg.mac, 6);
    push_bytes(48'(cfg.ip), 4);
    push_bytes(mac, 6);
    push_bytes(48'(ip), 4);
  endtask

  task automatic model_udp(input udp_dest_t d, input logic [15:0] len);
    logic [7:0]  h [20];
    logic [15:0] tot;
    logic [31:0] sum;
    tot = len + 16'd28;
    h = '{8'h45, 8'h00, tot[15:8], tot[7:0], 8'h00, 8'h00, 8'h40, 8'h00,
          8'd128, 8'd17, 8'h00, 8'h00,
          cfg.ip[31:24], cfg.ip[23:16], cfg.ip[15:8], cfg.ip[7:0],
          d.ip[31:24], d.ip[23:16], d.ip[15:8], d.ip[7:0]};
    sum = 32'h0;
    for (int i = 0; i < 20; i += 2)
      sum = sum + {16'h0, h[i], h[i+1]};
    while (sum[31:16] != 16'h0)
      sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    h[10] = ~sum[15:8];
    h[11] = ~sum[7:0];
    push_bytes(d.mac, 6);
    push_bytes(cfg.mac, 6);
    push_bytes(48'h0800, 2);
    for (int i = 0; i < 20; i++)
      exp_q.push_back(h[i]);
    push_bytes(48'd1024, 2);            // source port
    push_bytes(48'(d.port), 2);
    push_bytes(48'(len + 16'd8), 2);
    push_bytes(48'h0, 2);               // no udp checksum
    for (int i = 0; i < int'(len); i++)
      exp_q.push_back(pay[i]);
  endtask

  // --------------------------------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------------------------------
  task automatic set_dest(input entry_t e);
    @(posedge tx_clock);
    udp_dest <= '{mac: e.mac, ip: e.ip, port: e.port};
    run      <= (e.run_mode == 2'd1);
    @(posedge tx_clock);
    if (e.run_mode == 2'd2)
      run <= 1'b1;              // latched on this edge and frozen after
    if (e.run_mode != 2'd1)
      exp_dest = '{mac: e.mac, ip: e.ip, port: e.port};
  endtask

  // called right after a rising edge
  task automatic send_udp(input logic [15:0] len);
    int n;
    for (int i = 0; i < 64; i++)
      for (int b = 0; b < 8; b++)
        pay[i] = {pay[i][6:0], lfsr_bit()};
    pay_idx = 0;
    udp_tx_data    <= pay[0];
    udp_tx_length  <= len;
    udp_tx_request <= 1'b1;
    n = 0;
    do begin
      @(posedge tx_clock);
      n++;
    end while (!enable_seen && n < 300);
    udp_tx_request <= 1'b0;
    if (!enable_seen) begin
      $display("timeout: no udp_tx_enable grant after %0d cycles", n);
      timeouts++;
    end
  endtask

  task automatic wait_frames(input int target);
    int n;
    n = 0;
    while (frames_done < target && n < 400) begin
      @(posedge tx_clock);
      n++;
    end
    if (frames_done < target) begin
      $display("timeout: frame did not end after %0d cycles", n);
      timeouts++;
    end
  endtask

  task automatic check_frame(input int idx);
    assert (cap_q.size() == exp_q.size()) else begin
      $display("MISMATCH entry %0d frame length got %0h exp %0h", idx, cap_q.size(),
               exp_q.size());
      errors++;
    end
    for (int i = 0; i < cap_q.size() && i < exp_q.size(); i++)
      assert (cap_q[i] == exp_q[i]) else begin
        $display("MISMATCH entry %0d frame_out.data byte %0d got %02h exp %02h", idx, i,
                 cap_q[i], exp_q[i]);
        errors++;
      end
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    int base;
    rst_n = 1'b0;
    arp_request = 1'b0;
    udp_tx_request = 1'b0;
    run = 1'b0;
    cfg = '{mac: 48'h02_00_00_12_34_56, ip: 32'hc0a8_0164};
    arp_target = '0;
    udp_dest = '0;
    exp_dest = '0;
    udp_tx_length = '0;
    udp_tx_data = '0;
    lfsr = 16'd47;
    pay_idx = 0;
    frames_done = 0;
    errors = 0;
    timeouts = 0;
    read_seen = 1'b0;
    enable_seen = 1'b0;
    en_prev = 1'b0;
    table_e[0] = '{2'd0, 48'h0a_11_22_33_44_55, 32'hc0a8_0105, 16'd0,    16'd0,  2'd0};
    table_e[1] = '{2'd1, 48'h0c_01_02_03_04_05, 32'hc0a8_0110, 16'd5000, 16'd0,  2'd0};
    table_e[2] = '{2'd1, 48'h0c_01_02_03_04_05, 32'hc0a8_0110, 16'd5000, 16'd1,  2'd0};
    table_e[3] = '{2'd1, 48'h0c_01_02_03_04_05, 32'hc0a8_0110, 16'd5001, 16'd5,  2'd0};
    table_e[4] = '{2'd1, 48'h0e_aa_bb_cc_dd_ee, 32'h0a00_0002, 16'd53,   16'd18, 2'd0};
    table_e[5] = '{2'd2, 48'h0e_aa_bb_cc_dd_ee, 32'h0a00_0002, 16'd53,   16'd5,  2'd0};
    table_e[6] = '{2'd1, 48'h06_99_88_77_66_55, 32'h0a00_0077, 16'd7777, 16'd5,  2'd1};
    table_e[7] = '{2'd1, 48'h06_99_88_77_66_55, 32'h0a00_0077, 16'd7777, 16'd5,  2'd2};
    repeat (2) @(posedge tx_clock);
    rst_n <= 1'b1;

    // quiet outputs with nothing requested
    repeat (10) begin
      @(negedge tx_clock);
      assert (!frame_out.en && !tx_active && !udp_tx_enable && !udp_read) else begin
        $display("outputs active after reset with no request pending");
        errors++;
      end
    end

    for (int k = 0; k < N_ENTRIES; k++) begin
      if (table_e[k].kind != 2'd0)
        set_dest(table_e[k]);
      @(posedge tx_clock);
      cap_q.delete();
      exp_q.delete();
      base = frames_done;
      if (table_e[k].kind != 2'd1) begin
        arp_target  <= '{mac: table_e[k].mac, ip: table_e[k].ip};
        arp_request <= 1'b1;
        @(posedge tx_clock);
        arp_request <= 1'b0;
        model_arp(table_e[k].mac, table_e[k].ip);
      end
      if (table_e[k].kind != 2'd0) begin
        send_udp(table_e[k].len);   // arp pending one edge later so both are seen together
        model_udp(exp_dest, table_e[k].len);
      end
      wait_frames(base + ((table_e[k].kind == 2'd2) ? 2 : 1));
      check_frame(k);
    end

    repeat (3) @(posedge tx_clock);
    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
hdl/net_pkg.sv
hdl/arp_reply_gen.sv
hdl/udp_ip_gen.sv
hdl/eth_frame_tx.sv
hdl/net_tx_top.sv
tests/net_tx_assert.sv
tests/net_tx_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the transmit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module net_tx_tb -f list.f -o net_tx_sim || exit 1
./obj_dir/net_tx_sim > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0
